// File: verilog/rvPkg.sv
`default_nettype none

package rvPkg;

    localparam int XLEN = 32;
    localparam int REG_ADDR_W = 5;

    // RV32I major opcodes, instr[6:0]
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_BRANCH = 7'b1100011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
        ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_PASS_B
    } aluOp_e;

    typedef enum logic [2:0] {
        IMM_I, IMM_S, IMM_B, IMM_U, IMM_J
    } immType_e;

    // nine conditions, so one bit wider than the formats
    typedef enum logic [3:0] {
        BR_NONE, BR_JUMP, BR_JUMP_REG, BR_EQ, BR_NE, BR_LT, BR_GE, BR_LTU, BR_GEU
    } branchCond_e;

    typedef enum logic {
        SRC1_REG, SRC1_PC
    } src1Sel_e;

    typedef enum logic [1:0] {
        SRC2_REG, SRC2_IMM, SRC2_FOUR
    } src2Sel_e;

    typedef struct packed {
        aluOp_e      aluOp;
        immType_e    immType;
        src1Sel_e    src1Sel;
        src2Sel_e    src2Sel;
        branchCond_e branchCond;
        logic        regWrEn;
        logic        wbFromMem;
        logic        memWr;
        logic [2:0]  memOp;
    } ctrl_t;

    // data port request, address from the ALU
    typedef struct packed {
        logic [XLEN-1:0] addr;
        logic [XLEN-1:0] wdata;
        logic            wr;
        logic [2:0]      memOp;
    } dmemReq_t;

endpackage

`default_nettype wire

// File: verilog/pcUnit.sv
`timescale 1ns/1ps
`default_nettype none

module pcUnit #(
    parameter logic [rvPkg::XLEN-1:0] RESET_VECTOR = 32'h8000_0000
) (
    input  wire                      clk,
    input  wire                      rst_n,
    input  wire rvPkg::branchCond_e  branchCond_i,
    input  wire                      zero_i,
    input  wire                      less_i,
    input  wire [rvPkg::XLEN-1:0]    imm_i,
    input  wire [rvPkg::XLEN-1:0]    rs1Data_i,
    output logic [rvPkg::XLEN-1:0]   pc_o
);

    localparam logic [rvPkg::XLEN-1:0] PC_STEP = 4;

    logic                   taken;
    logic [rvPkg::XLEN-1:0] regTarget;
    logic [rvPkg::XLEN-1:0] nextPc;

    // flags come from SUB for EQ/NE and SLT/SLTU for the ordered compares
    always_comb begin
        case (branchCond_i)
            rvPkg::BR_JUMP, rvPkg::BR_JUMP_REG: taken = 1'b1;
            rvPkg::BR_EQ:                       taken = zero_i;
            rvPkg::BR_NE:                       taken = !zero_i;
            rvPkg::BR_LT, rvPkg::BR_LTU:        taken = less_i;
            rvPkg::BR_GE, rvPkg::BR_GEU:        taken = !less_i;
            default:                            taken = 1'b0;
        endcase
    end

    // jalr target has bit 0 cleared
    assign regTarget = rs1Data_i + imm_i;

    always_comb begin
        if (branchCond_i == rvPkg::BR_JUMP_REG) begin
            nextPc = {regTarget[rvPkg::XLEN-1:1], 1'b0};
        end else if (taken) begin
            nextPc = pc_o + imm_i;
        end else begin
            nextPc = pc_o + PC_STEP;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc_o <= RESET_VECTOR;
        end else begin
            pc_o <= nextPc;
        end
    end

    // holds only while programs keep jalr targets aligned, no trap here
    pcAligned: assert property (@(posedge clk) disable iff (!rst_n) pc_o[1:0] == 2'b00);

endmodule

`default_nettype wire

// File: verilog/decodeUnit.sv
`timescale 1ns/1ps
`default_nettype none

module decodeUnit (
    input  wire                          rst_n,
    input  wire [rvPkg::XLEN-1:0]        instr_i,
    output rvPkg::ctrl_t                 ctrl_o,
    output logic [rvPkg::REG_ADDR_W-1:0] rs1Addr_o,
    output logic [rvPkg::REG_ADDR_W-1:0] rs2Addr_o,
    output logic [rvPkg::REG_ADDR_W-1:0] rdAddr_o
);

    rvPkg::opcode_e opcode;
    logic [2:0]     funct3;

    // alt selects SUB / SRA, taken from funct7 bit 5
    function automatic rvPkg::aluOp_e aluFromFunct(input logic [2:0] f3, input logic alt);
        rvPkg::aluOp_e op;
        case (f3)
            3'b000:  op = alt ? rvPkg::ALU_SUB : rvPkg::ALU_ADD;
            3'b001:  op = rvPkg::ALU_SLL;
            3'b010:  op = rvPkg::ALU_SLT;
            3'b011:  op = rvPkg::ALU_SLTU;
            3'b100:  op = rvPkg::ALU_XOR;
            3'b101:  op = alt ? rvPkg::ALU_SRA : rvPkg::ALU_SRL;
            3'b110:  op = rvPkg::ALU_OR;
            default: op = rvPkg::ALU_AND;
        endcase
        return op;
    endfunction

    assign opcode    = rvPkg::opcode_e'(instr_i[6:0]);
    assign funct3    = instr_i[14:12];
    assign rs1Addr_o = instr_i[19:15];
    assign rs2Addr_o = instr_i[24:20];
    assign rdAddr_o  = instr_i[11:7];

    always_comb begin
        ctrl_o.aluOp      = rvPkg::ALU_ADD;
        ctrl_o.immType    = rvPkg::IMM_I;
        ctrl_o.src1Sel    = rvPkg::SRC1_REG;
        ctrl_o.src2Sel    = rvPkg::SRC2_REG;
        ctrl_o.branchCond = rvPkg::BR_NONE;
        ctrl_o.regWrEn    = 1'b0;
        ctrl_o.wbFromMem  = 1'b0;
        ctrl_o.memWr      = 1'b0;
        ctrl_o.memOp      = funct3;

        case (opcode)
            rvPkg::OPC_OP: begin
                ctrl_o.aluOp   = aluFromFunct(funct3, instr_i[30]);
                ctrl_o.regWrEn = 1'b1;
            end
            rvPkg::OPC_OP_IMM: begin
                // only srai uses funct7, addi has immediate bits there
                ctrl_o.aluOp   = aluFromFunct(funct3, funct3 == 3'b101 && instr_i[30]);
                ctrl_o.src2Sel = rvPkg::SRC2_IMM;
                ctrl_o.regWrEn = 1'b1;
            end
            rvPkg::OPC_LUI: begin
                ctrl_o.aluOp   = rvPkg::ALU_PASS_B;
                ctrl_o.immType = rvPkg::IMM_U;
                ctrl_o.src2Sel = rvPkg::SRC2_IMM;
                ctrl_o.regWrEn = 1'b1;
            end
            rvPkg::OPC_AUIPC: begin
                ctrl_o.immType = rvPkg::IMM_U;
                ctrl_o.src1Sel = rvPkg::SRC1_PC;
                ctrl_o.src2Sel = rvPkg::SRC2_IMM;
                ctrl_o.regWrEn = 1'b1;
            end
            rvPkg::OPC_JAL, rvPkg::OPC_JALR: begin
                // link value pc + 4 goes through the ALU
                ctrl_o.immType    = (opcode == rvPkg::OPC_JAL) ? rvPkg::IMM_J : rvPkg::IMM_I;
                ctrl_o.src1Sel    = rvPkg::SRC1_PC;
                ctrl_o.src2Sel    = rvPkg::SRC2_FOUR;
                ctrl_o.branchCond = (opcode == rvPkg::OPC_JAL) ? rvPkg::BR_JUMP
                                                               : rvPkg::BR_JUMP_REG;
                ctrl_o.regWrEn    = 1'b1;
            end
            rvPkg::OPC_BRANCH: begin
                ctrl_o.immType = rvPkg::IMM_B;
                case (funct3)
                    3'b000: {ctrl_o.branchCond, ctrl_o.aluOp} = {rvPkg::BR_EQ, rvPkg::ALU_SUB};
                    3'b001: {ctrl_o.branchCond, ctrl_o.aluOp} = {rvPkg::BR_NE, rvPkg::ALU_SUB};
                    3'b100: {ctrl_o.branchCond, ctrl_o.aluOp} = {rvPkg::BR_LT, rvPkg::ALU_SLT};
                    3'b101: {ctrl_o.branchCond, ctrl_o.aluOp} = {rvPkg::BR_GE, rvPkg::ALU_SLT};
                    3'b110: {ctrl_o.branchCond, ctrl_o.aluOp} = {rvPkg::BR_LTU, rvPkg::ALU_SLTU};
                    3'b111: {ctrl_o.branchCond, ctrl_o.aluOp} = {rvPkg::BR_GEU, rvPkg::ALU_SLTU};
                    default: ctrl_o.branchCond = rvPkg::BR_NONE;
                endcase
            end
            rvPkg::OPC_LOAD: begin
                ctrl_o.src2Sel   = rvPkg::SRC2_IMM;
                ctrl_o.regWrEn   = 1'b1;
                ctrl_o.wbFromMem = 1'b1;
            end
            rvPkg::OPC_STORE: begin
                ctrl_o.immType = rvPkg::IMM_S;
                ctrl_o.src2Sel = rvPkg::SRC2_IMM;
                ctrl_o.memWr   = 1'b1;
            end
            default: ;
        endcase

        // no architectural writes while in reset
        if (!rst_n) begin
            ctrl_o.regWrEn = 1'b0;
            ctrl_o.memWr   = 1'b0;
        end
    end

    // a store never writes back a register
    always_comb begin
        wrExclusive: assert (!(ctrl_o.regWrEn && ctrl_o.memWr));
    end

endmodule

`default_nettype wire

// File: verilog/immExpand.sv
`timescale 1ns/1ps
`default_nettype none

module immExpand (
    input  wire [rvPkg::XLEN-1:0]  instr_i,
    input  wire rvPkg::immType_e   immType_i,
    output logic [rvPkg::XLEN-1:0] imm_o
);

    logic sign;

    // every format takes its sign from bit 31
    assign sign = instr_i[31];

    always_comb begin
        case (immType_i)
            rvPkg::IMM_I: begin
                imm_o = {{(rvPkg::XLEN-12){sign}}, instr_i[31:20]};
            end
            rvPkg::IMM_S: begin
                imm_o = {{(rvPkg::XLEN-12){sign}}, instr_i[31:25], instr_i[11:7]};
            end
            rvPkg::IMM_B: begin
                // bit 0 is implied zero
                imm_o = {{(rvPkg::XLEN-13){sign}}, instr_i[31], instr_i[7],
                         instr_i[30:25], instr_i[11:8], 1'b0};
            end
            rvPkg::IMM_U: begin
                imm_o = {instr_i[31:12], 12'b0};
            end
            rvPkg::IMM_J: begin
                imm_o = {{(rvPkg::XLEN-21){sign}}, instr_i[31], instr_i[19:12],
                         instr_i[20], instr_i[30:21], 1'b0};
            end
            default: begin
                imm_o = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: verilog/aluUnit.sv
`timescale 1ns/1ps
`default_nettype none

module aluUnit (
    input  wire rvPkg::aluOp_e     op_i,
    input  wire [rvPkg::XLEN-1:0]  src1_i,
    input  wire [rvPkg::XLEN-1:0]  src2_i,
    output logic [rvPkg::XLEN-1:0] result_o,
    output logic                   zero_o,
    output logic                   less_o
);

    logic [4:0] shamt;
    logic       signedLess;
    logic       unsignedLess;

    assign shamt        = src2_i[4:0];
    assign signedLess   = $signed(src1_i) < $signed(src2_i);
    assign unsignedLess = src1_i < src2_i;

    always_comb begin
        case (op_i)
            rvPkg::ALU_ADD:    result_o = src1_i + src2_i;
            rvPkg::ALU_SUB:    result_o = src1_i - src2_i;
            rvPkg::ALU_SLL:    result_o = src1_i << shamt;
            rvPkg::ALU_SLT:    result_o = {{(rvPkg::XLEN-1){1'b0}}, signedLess};
            rvPkg::ALU_SLTU:   result_o = {{(rvPkg::XLEN-1){1'b0}}, unsignedLess};
            rvPkg::ALU_XOR:    result_o = src1_i ^ src2_i;
            rvPkg::ALU_SRL:    result_o = src1_i >> shamt;
            rvPkg::ALU_SRA:    result_o = $unsigned($signed(src1_i) >>> shamt);
            rvPkg::ALU_OR:     result_o = src1_i | src2_i;
            rvPkg::ALU_AND:    result_o = src1_i & src2_i;
            rvPkg::ALU_PASS_B: result_o = src2_i;
            default:           result_o = '0;
        endcase
    end

    // flags feed the branch decision in pcUnit
    assign zero_o = (result_o == '0);
    assign less_o = (op_i == rvPkg::ALU_SLTU) ? unsignedLess : signedLess;

endmodule

`default_nettype wire

// File: verilog/regFile.sv
`timescale 1ns/1ps
`default_nettype none

module regFile (
    input  wire                           clk,
    input  wire [rvPkg::REG_ADDR_W-1:0]   rs1Addr_i,
    input  wire [rvPkg::REG_ADDR_W-1:0]   rs2Addr_i,
    input  wire [rvPkg::REG_ADDR_W-1:0]   wrAddr_i,
    input  wire [rvPkg::XLEN-1:0]         wrData_i,
    input  wire                           wrEn_i,
    output logic [rvPkg::XLEN-1:0]        rs1Data_o,
    output logic [rvPkg::XLEN-1:0]        rs2Data_o
);

    logic [rvPkg::XLEN-1:0] regs [2**rvPkg::REG_ADDR_W];

    // x0 is never written
    always_ff @(posedge clk) begin
        if (wrEn_i && wrAddr_i != '0) begin
            regs[wrAddr_i] <= wrData_i;
        end
    end

    // combinational reads, x0 forced to zero
    assign rs1Data_o = (rs1Addr_i == '0) ? '0 : regs[rs1Addr_i];
    assign rs2Data_o = (rs2Addr_i == '0) ? '0 : regs[rs2Addr_i];

    x0ReadZero: assert property (@(posedge clk)
        (rs1Addr_i == '0 |-> rs1Data_o == '0) and (rs2Addr_i == '0 |-> rs2Data_o == '0));

endmodule

`default_nettype wire

// File: verilog/rvCore.sv
`timescale 1ns/1ps
`default_nettype none

module rvCore #(
    parameter logic [rvPkg::XLEN-1:0] RESET_VECTOR = 32'h8000_0000
) (
    input  wire                    clk,
    input  wire                    rst_n,
    input  wire [rvPkg::XLEN-1:0]  instr_i,
    input  wire [rvPkg::XLEN-1:0]  dmemRdata_i,
    output logic [rvPkg::XLEN-1:0] instrAddr_o,
    output rvPkg::dmemReq_t        dmemReq_o
);

    localparam logic [rvPkg::XLEN-1:0] LINK_STEP = 4;

    rvPkg::ctrl_t                 ctrl;
    logic [rvPkg::REG_ADDR_W-1:0] rs1Addr;
    logic [rvPkg::REG_ADDR_W-1:0] rs2Addr;
    logic [rvPkg::REG_ADDR_W-1:0] rdAddr;
    logic [rvPkg::XLEN-1:0]       pc;
    logic [rvPkg::XLEN-1:0]       imm;
    logic [rvPkg::XLEN-1:0]       rs1Data;
    logic [rvPkg::XLEN-1:0]       rs2Data;
    logic [rvPkg::XLEN-1:0]       aluSrc1;
    logic [rvPkg::XLEN-1:0]       aluSrc2;
    logic [rvPkg::XLEN-1:0]       aluResult;
    logic [rvPkg::XLEN-1:0]       wbData;
    logic                         zero;
    logic                         less;

    pcUnit #(
        .RESET_VECTOR(RESET_VECTOR)
    ) i_pcUnit (
        .clk          (clk),
        .rst_n        (rst_n),
        .branchCond_i (ctrl.branchCond),
        .zero_i       (zero),
        .less_i       (less),
        .imm_i        (imm),
        .rs1Data_i    (rs1Data),
        .pc_o         (pc)
    );

    decodeUnit i_decodeUnit (
        .rst_n     (rst_n),
        .instr_i   (instr_i),
        .ctrl_o    (ctrl),
        .rs1Addr_o (rs1Addr),
        .rs2Addr_o (rs2Addr),
        .rdAddr_o  (rdAddr)
    );

    immExpand i_immExpand (
        .instr_i   (instr_i),
        .immType_i (ctrl.immType),
        .imm_o     (imm)
    );

    // operand muxes
    assign aluSrc1 = (ctrl.src1Sel == rvPkg::SRC1_PC) ? pc : rs1Data;

    always_comb begin
        case (ctrl.src2Sel)
            rvPkg::SRC2_IMM:  aluSrc2 = imm;
            rvPkg::SRC2_FOUR: aluSrc2 = LINK_STEP;
            default:          aluSrc2 = rs2Data;
        endcase
    end

    aluUnit i_aluUnit (
        .op_i     (ctrl.aluOp),
        .src1_i   (aluSrc1),
        .src2_i   (aluSrc2),
        .result_o (aluResult),
        .zero_o   (zero),
        .less_o   (less)
    );

    assign wbData = ctrl.wbFromMem ? dmemRdata_i : aluResult;

    regFile i_regFile (
        .clk       (clk),
        .rs1Addr_i (rs1Addr),
        .rs2Addr_i (rs2Addr),
        .wrAddr_i  (rdAddr),
        .wrData_i  (wbData),
        .wrEn_i    (ctrl.regWrEn),
        .rs1Data_o (rs1Data),
        .rs2Data_o (rs2Data)
    );

    assign instrAddr_o = pc;
    assign dmemReq_o = '{addr: aluResult, wdata: rs2Data, wr: ctrl.memWr, memOp: ctrl.memOp};

    // store strobe must stay quiet while the PC is being reset
    noStoreInReset: assert property (@(posedge clk) !rst_n |-> !dmemReq_o.wr);

endmodule

`default_nettype wire

// File: include/tbCheckTasks.svh
`ifndef TB_CHECK_TASKS_SVH
`define TB_CHECK_TASKS_SVH

int errCount = 0;
int checkCount = 0;

// data value compare
task automatic checkWord(input string name, input logic [rvPkg::XLEN-1:0] got,
                         input logic [rvPkg::XLEN-1:0] exp);
    checkCount++;
    if (got !== exp) begin
        errCount++;
        $display("** Error %s: got %h, expected %h at %0t", name, got, exp, $time);
    end
endtask

// whole data port request
task automatic checkReq(input string name, input rvPkg::dmemReq_t got,
                        input rvPkg::dmemReq_t exp);
    checkCount++;
    if (got !== exp) begin
        errCount++;
        $display("** Error dmemReq_o (%s): got addr %h wdata %h wr %h memOp %h", name,
                 got.addr, got.wdata, got.wr, got.memOp);
        $display("         expected addr %h wdata %h wr %h memOp %h",
                 exp.addr, exp.wdata, exp.wr, exp.memOp);
    end
endtask

task automatic checkPc(input logic [rvPkg::XLEN-1:0] got, input logic [rvPkg::XLEN-1:0] exp);
    checkCount++;
    if (got !== exp) begin
        errCount++;
        $display("** Error instrAddr_o: got %h, expected %h at %0t", got, exp, $time);
    end
endtask

`endif

// File: test/tbRvCore.sv
`timescale 1ns/1ps
`default_nettype none

module tbRvCore;

    localparam logic [31:0] RESET_VECTOR = 32'h8000_0000;
    localparam int RESET_CYCLES = 5;
    localparam int ALU_CYCLES = 26;
    localparam int IMM_CYCLES = 11;
    localparam int BR_CYCLES = 20;
    localparam int JMP_CYCLES = 7;
    localparam int MEM_CYCLES = 8;
    localparam int CYCLE_LIMIT = 5 * RESET_CYCLES + ALU_CYCLES + IMM_CYCLES + BR_CYCLES
                                 + JMP_CYCLES + MEM_CYCLES + 50;
    // addi x0, x0, 0
    localparam logic [31:0] NOP = 32'h0000_0013;

    logic            clk;
    logic            rst_n;
    logic [31:0]     instrWord;
    logic [31:0]     rdata;
    logic [31:0]     instrAddr;
    logic [31:0]     pcOffset;
    rvPkg::dmemReq_t dmemReq;

    logic [31:0]     imem [64];
    logic [31:0]     dmem [1024];
    rvPkg::dmemReq_t storeLog [$];
    rvPkg::dmemReq_t expStores [$];
    bit              takenAt [64];
    int              progLen;
    int              cycles = 0;
    integer          seed;

    `include "tbCheckTasks.svh"

    rvCore #(
        .RESET_VECTOR(RESET_VECTOR)
    ) i_dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr_i     (instrWord),
        .dmemRdata_i (rdata),
        .instrAddr_o (instrAddr),
        .dmemReq_o   (dmemReq)
    );

    // both memories read combinationally
    assign pcOffset  = instrAddr - RESET_VECTOR;
    assign instrWord = imem[pcOffset[7:2]];
    assign rdata     = dmem[dmemReq.addr[11:2]];

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // store monitor, every access is a full word
    always @(posedge clk) begin
        if (dmemReq.wr === 1'b1) begin
            storeLog.push_back(dmemReq);
            dmem[dmemReq.addr[11:2]] <= dmemReq.wdata;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > CYCLE_LIMIT) begin
            $display("timeout, the run went past %0d cycles", CYCLE_LIMIT);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    function automatic logic [31:0] sext12(input logic [11:0] v);
        return {{20{v[11]}}, v};
    endfunction

    // fill value mixes in every address bit
    function automatic logic [31:0] fillWord(input logic [31:0] addr);
        return {addr[15:0], ~addr[15:0]} ^ addr;
    endfunction

    function automatic logic [31:0] rType(input logic [2:0] f3, input logic alt,
                                         input logic [4:0] rd, input logic [4:0] rs1,
                                         input logic [4:0] rs2);
        return {1'b0, alt, 5'b0, rs2, rs1, f3, rd, rvPkg::OPC_OP};
    endfunction

    function automatic logic [31:0] iType(input rvPkg::opcode_e opc, input logic [2:0] f3,
                                         input logic [4:0] rd, input logic [4:0] rs1,
                                         input logic [11:0] imm);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] sType(input logic [2:0] f3, input logic [4:0] rs1,
                                         input logic [4:0] rs2, input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], rvPkg::OPC_STORE};
    endfunction

    function automatic logic [31:0] bType(input logic [2:0] f3, input logic [4:0] rs1,
                                         input logic [4:0] rs2, input logic [12:0] imm);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], rvPkg::OPC_BRANCH};
    endfunction

    function automatic logic [31:0] uType(input rvPkg::opcode_e opc, input logic [4:0] rd,
                                         input logic [19:0] imm);
        return {imm, rd, opc};
    endfunction

    function automatic logic [31:0] jType(input logic [4:0] rd, input logic [20:0] imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, rvPkg::OPC_JAL};
    endfunction

    // RV32I register-register results, shift amount from b[4:0]
    function automatic logic [31:0] aluReference(input logic [2:0] f3, input logic alt,
                                                 input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << b[4:0];
            3'd2:    return {31'b0, $signed(a) < $signed(b)};
            3'd3:    return {31'b0, a < b};
            3'd4:    return a ^ b;
            3'd5:    return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic bit branchTaken(input logic [2:0] f3, input logic [31:0] a,
                                       input logic [31:0] b);
        case (f3)
            3'b000:  return a == b;
            3'b001:  return a != b;
            3'b100:  return $signed(a) < $signed(b);
            3'b101:  return $signed(a) >= $signed(b);
            3'b110:  return a < b;
            default: return a >= b;
        endcase
    endfunction

    task automatic clearProgram();
        for (int i = 0; i < 64; i++) begin
            imem[i] = NOP;
            takenAt[i] = 1'b0;
        end
        progLen = 0;
        storeLog.delete();
        expStores.delete();
    endtask

    task automatic emit(input logic [31:0] word);
        imem[progLen] = word;
        progLen++;
    endtask

    // upper part rounded up when the low twelve bits are negative
    task automatic loadConst(input logic [4:0] rd, input logic [31:0] value);
        emit(uType(rvPkg::OPC_LUI, rd, value[31:12] + {19'b0, value[11]}));
        emit(iType(rvPkg::OPC_OP_IMM, 3'b000, rd, rd, value[11:0]));
    endtask

    task automatic stepCycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #5;
        end
    endtask

    task automatic applyReset();
        rst_n = 1'b0;
        repeat (RESET_CYCLES) begin
            @(posedge clk);
            #5;
            checkPc(instrAddr, RESET_VECTOR);
            checkWord("dmemReq_o.wr", {31'b0, dmemReq.wr}, 32'h0);
        end
        rst_n = 1'b1;
        // first cycle out of reset still fetches the reset vector
        checkPc(instrAddr, RESET_VECTOR);
    endtask

    task automatic expectStore(input logic [31:0] addr, input logic [31:0] data,
                               input logic [2:0] op);
        rvPkg::dmemReq_t req;
        req.addr = addr;
        req.wdata = data;
        req.wr = 1'b1;
        req.memOp = op;
        expStores.push_back(req);
    endtask

    task automatic compareStores(input string testName);
        if (storeLog.size() != expStores.size()) begin
            errCount++;
            $display("%s: saw %0d stores where %0d were expected", testName,
                     storeLog.size(), expStores.size());
        end else begin
            foreach (expStores[i]) begin
                checkReq($sformatf("%s store %0d", testName, i), storeLog[i], expStores[i]);
            end
        end
    endtask

    task automatic aluOps();
        logic [31:0] a;
        logic [31:0] b;
        logic [2:0]  f3s [10];
        logic        alts [10];
        f3s = '{3'd0, 3'd0, 3'd1, 3'd2, 3'd3, 3'd4, 3'd5, 3'd5, 3'd6, 3'd7};
        alts = '{1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0};
        a = $random(seed);
        b = $random(seed);
        clearProgram();
        loadConst(5'd1, a);
        loadConst(5'd2, b);
        for (int k = 0; k < 10; k++) begin
            emit(rType(f3s[k], alts[k], 5'd3, 5'd1, 5'd2));
            emit(sType(3'b010, 5'd0, 5'd3, 12'(4 * k)));
            expectStore(4 * k, aluReference(f3s[k], alts[k], a, b), 3'b010);
        end
        // write to x0 is dropped
        emit(iType(rvPkg::OPC_OP_IMM, 3'b000, 5'd0, 5'd0, 12'h123));
        emit(sType(3'b010, 5'd0, 5'd0, 12'h100));
        expectStore(32'h100, 32'h0, 3'b010);
        applyReset();
        stepCycles(ALU_CYCLES);
        compareStores("alu");
    endtask

    task automatic immediateForms();
        clearProgram();
        // store sits at the reset vector, so wr is fetched while in reset
        emit(sType(3'b010, 5'd0, 5'd0, 12'h00C));
        emit(iType(rvPkg::OPC_OP_IMM, 3'b000, 5'd5, 5'd0, 12'hFFB));
        emit(iType(rvPkg::OPC_OP_IMM, 3'b000, 5'd6, 5'd0, 12'h7FF));
        emit(uType(rvPkg::OPC_LUI, 5'd7, 20'hFFFFF));
        emit(iType(rvPkg::OPC_OP_IMM, 3'b100, 5'd9, 5'd6, 12'hFFF));
        emit(iType(rvPkg::OPC_OP_IMM, 3'b000, 5'd8, 5'd0, 12'h200));
        emit(sType(3'b010, 5'd0, 5'd5, 12'h010));
        emit(sType(3'b010, 5'd0, 5'd6, 12'h014));
        emit(sType(3'b010, 5'd0, 5'd7, 12'h018));
        emit(sType(3'b010, 5'd0, 5'd9, 12'h01C));
        // negative store offset from x8
        emit(sType(3'b010, 5'd8, 5'd5, 12'hFF8));
        expectStore(32'hC, 32'h0, 3'b010);
        expectStore(32'h10, sext12(12'hFFB), 3'b010);
        expectStore(32'h14, sext12(12'h7FF), 3'b010);
        expectStore(32'h18, {20'hFFFFF, 12'h000}, 3'b010);
        expectStore(32'h1C, sext12(12'h7FF) ^ sext12(12'hFFF), 3'b010);
        expectStore(sext12(12'h200) + sext12(12'hFF8), sext12(12'hFFB), 3'b010);
        applyReset();
        stepCycles(IMM_CYCLES);
        compareStores("immediate");
    endtask

    task automatic branchConditions();
        logic [2:0]  f3s [12];
        logic [4:0]  lhs [12];
        logic [4:0]  rhs [12];
        logic [31:0] regVal [3];
        logic [31:0] pcModel;
        int          idx;
        // each condition once taken, once not taken
        f3s = '{3'd0, 3'd0, 3'd1, 3'd1, 3'd4, 3'd4, 3'd5, 3'd5, 3'd6, 3'd6, 3'd7, 3'd7};
        lhs = '{5'd1, 5'd1, 5'd1, 5'd1, 5'd2, 5'd1, 5'd1, 5'd2, 5'd1, 5'd2, 5'd2, 5'd1};
        rhs = '{5'd1, 5'd2, 5'd2, 5'd1, 5'd1, 5'd2, 5'd2, 5'd1, 5'd2, 5'd1, 5'd1, 5'd2};
        regVal[0] = 32'h0;
        regVal[1] = sext12(12'h005);
        regVal[2] = sext12(12'hFFD);
        clearProgram();
        emit(iType(rvPkg::OPC_OP_IMM, 3'b000, 5'd1, 5'd0, 12'h005));
        emit(iType(rvPkg::OPC_OP_IMM, 3'b000, 5'd2, 5'd0, 12'hFFD));
        for (int k = 0; k < 12; k++) begin
            takenAt[progLen] = branchTaken(f3s[k], regVal[lhs[k]], regVal[rhs[k]]);
            // taken branch skips the nop after it
            emit(bType(f3s[k], lhs[k], rhs[k], 13'd8));
            emit(NOP);
        end
        applyReset();
        pcModel = RESET_VECTOR;
        for (int c = 0; c < BR_CYCLES; c++) begin
            checkPc(instrAddr, pcModel);
            idx = (pcModel - RESET_VECTOR) >> 2;
            pcModel = takenAt[idx] ? pcModel + 32'd8 : pcModel + 32'd4;
            stepCycles(1);
        end
        compareStores("branch");
    endtask

    task automatic jumpsAndLinks();
        logic [31:0] pcPath [7];
        logic [31:0] jalrTarget;
        clearProgram();
        emit(jType(5'd1, 21'd8));
        emit(sType(3'b010, 5'd0, 5'd0, 12'h04C));
        emit(sType(3'b010, 5'd0, 5'd1, 12'h040));
        emit(uType(rvPkg::OPC_AUIPC, 5'd2, 20'h12345));
        emit(sType(3'b010, 5'd0, 5'd2, 12'h044));
        emit(uType(rvPkg::OPC_AUIPC, 5'd3, 20'h00000));
        // odd target, bit 0 must be dropped
        emit(iType(rvPkg::OPC_JALR, 3'b000, 5'd4, 5'd3, 12'd13));
        emit(sType(3'b010, 5'd0, 5'd0, 12'h04C));
        emit(sType(3'b010, 5'd0, 5'd4, 12'h048));
        jalrTarget = (RESET_VECTOR + 32'd20 + sext12(12'd13)) & ~32'h1;
        pcPath = '{RESET_VECTOR, RESET_VECTOR + 32'd8, RESET_VECTOR + 32'd12,
                   RESET_VECTOR + 32'd16, RESET_VECTOR + 32'd20, RESET_VECTOR + 32'd24,
                   jalrTarget};
        expectStore(32'h40, RESET_VECTOR + 32'd4, 3'b010);
        expectStore(32'h44, RESET_VECTOR + 32'd12 + {20'h12345, 12'h000}, 3'b010);
        expectStore(32'h48, RESET_VECTOR + 32'd24 + 32'd4, 3'b010);
        applyReset();
        for (int c = 0; c < JMP_CYCLES; c++) begin
            checkPc(instrAddr, pcPath[c]);
            stepCycles(1);
        end
        compareStores("jump");
    endtask

    task automatic memoryRoundTrip();
        logic [31:0]     v;
        rvPkg::dmemReq_t loadReq;
        v = $random(seed);
        clearProgram();
        loadConst(5'd1, v);
        emit(sType(3'b010, 5'd0, 5'd1, 12'h080));
        emit(iType(rvPkg::OPC_LOAD, 3'b010, 5'd2, 5'd0, 12'h080));
        emit(sType(3'b010, 5'd0, 5'd2, 12'h084));
        // untouched word, load returns the fill value
        emit(iType(rvPkg::OPC_LOAD, 3'b010, 5'd3, 5'd0, 12'h090));
        emit(sType(3'b010, 5'd0, 5'd3, 12'h094));
        emit(sType(3'b000, 5'd0, 5'd1, 12'h088));
        expectStore(32'h80, v, 3'b010);
        expectStore(32'h84, v, 3'b010);
        expectStore(32'h94, fillWord(32'h90), 3'b010);
        expectStore(32'h88, v, 3'b000);
        // rs2 field of this lw is x0
        loadReq.addr = 32'h80;
        loadReq.wdata = 32'h0;
        loadReq.wr = 1'b0;
        loadReq.memOp = 3'b010;
        applyReset();
        stepCycles(3);
        checkReq("lw request", dmemReq, loadReq);
        stepCycles(MEM_CYCLES - 3);
        compareStores("memory");
    endtask

    initial begin
        rst_n = 1'b0;
        seed = 75276;
        for (int i = 0; i < 1024; i++) begin
            dmem[i] <= fillWord(i * 4);
        end
        clearProgram();
        aluOps();
        immediateForms();
        branchConditions();
        jumpsAndLinks();
        memoryRoundTrip();
        $display("checks %0d, errors %0d", checkCount, errCount);
        if (errCount == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: compile.f
+incdir+include
verilog/rvPkg.sv
verilog/pcUnit.sv
verilog/decodeUnit.sv
verilog/immExpand.sv
verilog/aluUnit.sv
verilog/regFile.sv
verilog/rvCore.sv
test/tbRvCore.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the rvCore testbench with Verilator, verdict taken from the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --assert -f compile.f --top-module tbRvCore -Mdir obj_dir -o tbRvCore \
    && ./obj_dir/tbRvCore > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or simulation aborted"; exit 1; }

cat sim.log
grep -q "STATUS: FAIL" sim.log && { echo "simulation reported failure"; exit 1; }
grep -q "STATUS: PASS" sim.log || { echo "no verdict found in sim.log"; exit 1; }
exit 0
